// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps
/* Testbench clock and reset
   10 ns clock, active-low reset held for five cycles */

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int unsigned ResetCycles = 5;

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Release just after an edge, like the other stimulus
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

// ==== dv/tb_lane.sv ====
`timescale 1ns/1ps
/* Vector lane testbench
   Random load, ALU and STORE traffic checked against a register file model */

`include "lane_cfg.svh"

module tb_lane import lane_isa_pkg::*; import lane_bus_pkg::*; ();

  localparam int unsigned NrIter        = 80;
  localparam int unsigned NrStores      = 20;
  localparam int unsigned TimeoutCycles = 200 * 40;

  logic    clk_i, rst_ni;
  vinsn_t  insn_i;
  logic    insn_valid_i, insn_ready_o;
  ldu_wr_t ldu_wr_i;
  logic    ldu_valid_i, ldu_ready_o;
  elem_t   stu_operand_o;
  logic    stu_valid_o, stu_ready_i;
  logic    done_o;
  vid_t    done_id_o;

  integer      seed;
  int unsigned cycles;
  int unsigned done_cnt;
  vid_t        next_id;
  elem_t       model [`LANE_NR_VREGS][`LANE_VLMAX];
  elem_t       stu_got [$];
  vid_t        id_exp [$];

  tb_clk_gen tb_clk_gen_inst (
    .clk_o (clk_i),
    .rst_no(rst_ni)
  );

  lane lane_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .insn_i       (insn_i),
    .insn_valid_i (insn_valid_i),
    .insn_ready_o (insn_ready_o),
    .ldu_wr_i     (ldu_wr_i),
    .ldu_valid_i  (ldu_valid_i),
    .ldu_ready_o  (ldu_ready_o),
    .stu_operand_o(stu_operand_o),
    .stu_valid_o  (stu_valid_o),
    .stu_ready_i  (stu_ready_i),
    .done_o       (done_o),
    .done_id_o    (done_id_o)
  );

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic fail_now();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_elem(string name, elem_t exp, elem_t act);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s expected %h, actual %h", $time, name, exp, act);
      fail_now();
    end
  endtask

  task automatic check_id(string name, vid_t exp, vid_t act);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s expected %0d, actual %0d", $time, name, exp, act);
      fail_now();
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("Mismatch at %0t: %s expected %b, actual %b", $time, name, exp, act);
      fail_now();
    end
  endtask

  function automatic int unsigned rand_range(int unsigned n);
    logic [31:0] r;
    r = $random(seed);
    return r % n;
  endfunction

  // Element-wise result as defined for each operation
  function automatic elem_t apply_op(vop_e op, elem_t a, elem_t b);
    case (op)
      VOP_ADD: return a + b;
      VOP_SUB: return a - b;
      VOP_AND: return a & b;
      VOP_OR:  return a | b;
      VOP_XOR: return a ^ b;
      default: return b;
    endcase
  endfunction

  ////////////////////////////////////////
  // Cycle step and port monitors
  ////////////////////////////////////////

  // Outputs are sampled 1 ns after the edge, where they only depend on state
  task automatic step();
    @(posedge clk_i);
    #1;
    cycles++;
    if (cycles > TimeoutCycles) begin
      $display("Timeout after %0d cycles, the lane stopped making progress", cycles);
      fail_now();
    end
    if (done_o) begin
      if (id_exp.size() == 0) begin
        $display("Completion pulse at %0t with no outstanding instruction", $time);
        fail_now();
      end
      check_id("done_id_o", id_exp.pop_front(), done_id_o);
      done_cnt++;
    end
    // Valid is stable until the next edge, so a transfer is known here
    stu_ready_i = (rand_range(10) < 7);
    if (stu_valid_o && stu_ready_i) stu_got.push_back(stu_operand_o);
  endtask

  task automatic load_write(vreg_t r, velem_t i, elem_t d);
    logic accepted;
    ldu_wr_i    = '{vreg: r, idx: i, data: d};
    ldu_valid_i = 1'b1;
    accepted    = 1'b0;
    while (!accepted) begin
      accepted = ldu_ready_o;
      step();
    end
    ldu_valid_i = 1'b0;
    model[r][i] = d;
    // Spill entry drains into the bank
    while (!ldu_ready_o) step();
  endtask

  task automatic exec_insn(vinsn_t insn);
    logic        accepted;
    int unsigned done_before;
    done_before  = done_cnt;
    id_exp.push_back(insn.id);
    insn_i       = insn;
    insn_valid_i = 1'b1;
    accepted     = 1'b0;
    while (!accepted) begin
      accepted = insn_ready_o;
      step();
    end
    insn_valid_i = 1'b0;
    next_id++;
    while (done_cnt == done_before) step();
  endtask

  task automatic run_store(vreg_t r, vlen_t vl);
    vinsn_t insn;
    insn = '{op: VOP_STORE, vd: '0, vs1: '0, vs2: r, vl: vl, id: next_id};
    stu_got.delete();
    exec_insn(insn);
    if (stu_got.size() != int'(vl)) begin
      $display("STORE of v%0d delivered %0d elements, expected %0d", r, stu_got.size(), vl);
      fail_now();
    end
    for (int i = 0; i < int'(vl); i++) begin
      check_elem($sformatf("stu_operand_o[%0d] of v%0d", i, r), model[r][i], stu_got[i]);
    end
  endtask

  task automatic run_alu(vop_e op, vreg_t vd, vreg_t vs1, vreg_t vs2, vlen_t vl);
    vinsn_t insn;
    insn = '{op: op, vd: vd, vs1: vs1, vs2: vs2, vl: vl, id: next_id};
    stu_got.delete();
    exec_insn(insn);
    if (stu_got.size() != 0) begin
      $display("Store port transferred data during ALU instruction %0d", insn.id);
      fail_now();
    end
    // Element i only depends on element i, so in-place update is safe
    for (int i = 0; i < int'(vl); i++) begin
      model[vd][i] = apply_op(op, model[vs1][i], model[vs2][i]);
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin : stimulus
    vop_e  op;
    vreg_t vd, vs1, vs2;
    vlen_t vl;
    seed         = 32'hd887_8d3b;
    cycles       = 0;
    done_cnt     = 0;
    next_id      = '0;
    insn_i       = '0;
    insn_valid_i = 1'b0;
    ldu_wr_i     = '0;
    ldu_valid_i  = 1'b0;
    stu_ready_i  = 1'b0;

    wait (rst_ni === 1'b1);
    step();
    check_flag("insn_ready_o", 1'b1, insn_ready_o);
    check_flag("done_o", 1'b0, done_o);
    check_flag("stu_valid_o", 1'b0, stu_valid_o);
    check_flag("ldu_ready_o", 1'b1, ldu_ready_o);

    // Register contents start undefined
    for (int r = 0; r < `LANE_NR_VREGS; r++) begin
      for (int i = 0; i < `LANE_VLMAX; i++) begin
        load_write(vreg_t'(r), velem_t'(i), elem_t'($random(seed)));
      end
    end
    for (int r = 0; r < `LANE_NR_VREGS; r++) run_store(vreg_t'(r), vlen_t'(`LANE_VLMAX));

    for (int it = 0; it < NrIter; it++) begin
      op  = vop_e'(rand_range(5));
      vd  = vreg_t'(rand_range(`LANE_NR_VREGS));
      vs1 = vreg_t'(rand_range(`LANE_NR_VREGS));
      // Same bank parity in half of the iterations
      case (it % 4)
        0:       vs2 = vs1;
        1:       vs2 = vs1 ^ vreg_t'(2);
        default: vs2 = vreg_t'(rand_range(`LANE_NR_VREGS));
      endcase
      vl = vlen_t'(1 + rand_range(`LANE_VLMAX));
      if (rand_range(4) == 0) begin
        load_write(vreg_t'(rand_range(`LANE_NR_VREGS)), velem_t'(rand_range(`LANE_VLMAX)),
                   elem_t'($random(seed)));
      end
      run_alu(op, vd, vs1, vs2, vl);
      // Full-length readback also covers the tail beyond vl
      run_store(vd, vlen_t'(`LANE_VLMAX));
    end

    for (int k = 0; k < NrStores; k++) begin
      run_store(vreg_t'(rand_range(`LANE_NR_VREGS)), vlen_t'(1 + rand_range(`LANE_VLMAX)));
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== hdl/lane.sv ====
`timescale 1ns/1ps
/* Vector lane top level
   Sequencer, operand requester, register file, operand queues and ALU */

`include "lane_cfg.svh"

module lane import lane_isa_pkg::*; import lane_bus_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  vinsn_t  insn_i,
  input  logic    insn_valid_i,
  output logic    insn_ready_o,
  input  ldu_wr_t ldu_wr_i,
  input  logic    ldu_valid_i,
  output logic    ldu_ready_o,
  output elem_t   stu_operand_o,
  output logic    stu_valid_o,
  input  logic    stu_ready_i,
  output logic    done_o,
  output vid_t    done_id_o
);

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  vinsn_t   cmd;
  logic     cmd_valid, cmd_ready;
  alu_cmd_t alu_cmd;
  logic     alu_cmd_valid, alu_cmd_ready, alu_idle, wb_done;

  lane_sequencer lane_sequencer_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .insn_i         (insn_i),
    .insn_valid_i   (insn_valid_i),
    .insn_ready_o   (insn_ready_o),
    .cmd_o          (cmd),
    .cmd_valid_o    (cmd_valid),
    .cmd_ready_i    (cmd_ready),
    .alu_cmd_o      (alu_cmd),
    .alu_cmd_valid_o(alu_cmd_valid),
    .alu_cmd_ready_i(alu_cmd_ready),
    .wb_done_i      (wb_done),
    .alu_idle_i     (alu_idle),
    .done_o         (done_o),
    .done_id_o      (done_id_o)
  );

  ////////////////////////////////////////
  // Register file access
  ////////////////////////////////////////

  vrf_req_t [`LANE_NR_BANKS-1:0] vrf_req;
  logic     [`LANE_NR_BANKS-1:0] vrf_req_valid;
  elem_t    [1:0]                vrf_rdata;
  logic     [1:0]                vrf_rdata_valid;
  ldu_wr_t                       ldu_wr;
  logic                          ldu_valid, ldu_ready;
  logic                          qa_ready, qb_ready;
  elem_t                         alu_res;
  logic                          alu_res_valid, alu_res_ready;

  // Single-entry buffer on the load write port
  stream_buffer #(.payload_t(ldu_wr_t), .Depth(1)) ldu_buffer_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (ldu_wr_i),
    .valid_i(ldu_valid_i),
    .ready_o(ldu_ready_o),
    .data_o (ldu_wr),
    .valid_o(ldu_valid),
    .ready_i(ldu_ready)
  );

  operand_requester operand_requester_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cmd_i          (cmd),
    .cmd_valid_i    (cmd_valid),
    .cmd_ready_o    (cmd_ready),
    .vrf_req_o      (vrf_req),
    .vrf_req_valid_o(vrf_req_valid),
    .qa_ready_i     (qa_ready),
    .qb_ready_i     (qb_ready),
    .alu_res_i      (alu_res),
    .alu_res_valid_i(alu_res_valid),
    .alu_res_ready_o(alu_res_ready),
    .ldu_wr_i       (ldu_wr),
    .ldu_valid_i    (ldu_valid),
    .ldu_ready_o    (ldu_ready),
    .wb_done_o      (wb_done)
  );

  vector_regfile vector_regfile_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (vrf_req),
    .req_valid_i  (vrf_req_valid),
    .rdata_o      (vrf_rdata),
    .rdata_valid_o(vrf_rdata_valid)
  );

  ////////////////////////////////////////
  // Operand queues and ALU
  ////////////////////////////////////////

  elem_t opa, opb;
  logic  opa_valid, opa_ready, opb_valid, opb_ready;

  stream_buffer #(.payload_t(elem_t), .Depth(`LANE_QUEUE_DEPTH)) queue_a_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (vrf_rdata[OPQ_A]),
    .valid_i(vrf_rdata_valid[OPQ_A]),
    .ready_o(qa_ready),
    .data_o (opa),
    .valid_o(opa_valid),
    .ready_i(opa_ready)
  );

  stream_buffer #(.payload_t(elem_t), .Depth(`LANE_QUEUE_DEPTH)) queue_b_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (vrf_rdata[OPQ_B]),
    .valid_i(vrf_rdata_valid[OPQ_B]),
    .ready_o(qb_ready),
    .data_o (opb),
    .valid_o(opb_valid),
    .ready_i(opb_ready)
  );

  vector_alu vector_alu_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_i        (alu_cmd),
    .cmd_valid_i  (alu_cmd_valid),
    .cmd_ready_o  (alu_cmd_ready),
    .opa_i        (opa),
    .opa_valid_i  (opa_valid),
    .opa_ready_o  (opa_ready),
    .opb_i        (opb),
    .opb_valid_i  (opb_valid),
    .opb_ready_o  (opb_ready),
    .res_o        (alu_res),
    .res_valid_o  (alu_res_valid),
    .res_ready_i  (alu_res_ready),
    .stu_operand_o(stu_operand_o),
    .stu_valid_o  (stu_valid_o),
    .stu_ready_i  (stu_ready_i),
    .idle_o       (alu_idle)
  );

endmodule

// ==== hdl/lane_bus_pkg.sv ====
/* Vector lane internal transfer types
   Register file accesses, load writes and ALU commands */

`include "lane_cfg.svh"

package lane_bus_pkg;

  import lane_isa_pkg::*;

  // Word address inside one bank
  typedef logic [$clog2(`LANE_NR_VREGS * `LANE_VLMAX / `LANE_NR_BANKS)-1:0] vaddr_t;

  typedef enum logic {
    OPQ_A,
    OPQ_B
  } opqueue_e;

  typedef struct packed {
    logic     we;
    vaddr_t   addr;
    elem_t    wdata;
    opqueue_e tgt;
  } vrf_req_t;

  typedef struct packed {
    vreg_t  vreg;
    velem_t idx;
    elem_t  data;
  } ldu_wr_t;

  typedef struct packed {
    vop_e  op;
    vlen_t vl;
  } alu_cmd_t;

endpackage

// ==== hdl/lane_cfg.svh ====
/* Vector lane configuration
   Element width, register file geometry and operand queue depth */

`ifndef LANE_CFG_SVH
`define LANE_CFG_SVH

// Element width in bits
`define LANE_ELEN 32

// Register file geometry
`define LANE_NR_VREGS 8
`define LANE_VLMAX 8
`define LANE_NR_BANKS 2

// Entries per operand queue
`define LANE_QUEUE_DEPTH 4

`endif

// ==== hdl/lane_isa_pkg.sv ====
/* Vector lane instruction types
   Operation codes, register and element indices, instruction format */

`include "lane_cfg.svh"

package lane_isa_pkg;

  typedef enum logic [2:0] {
    VOP_ADD,
    VOP_SUB,
    VOP_AND,
    VOP_OR,
    VOP_XOR,
    VOP_STORE
  } vop_e;

  typedef logic [$clog2(`LANE_NR_VREGS)-1:0] vreg_t;
  typedef logic [$clog2(`LANE_VLMAX)-1:0]    velem_t;
  // One bit wider than velem_t so that vl can reach VLMAX
  typedef logic [$clog2(`LANE_VLMAX):0]      vlen_t;
  typedef logic [3:0]                        vid_t;
  typedef logic [`LANE_ELEN-1:0]             elem_t;

  typedef struct packed {
    vop_e  op;
    vreg_t vd;
    vreg_t vs1;
    vreg_t vs2;
    vlen_t vl;
    vid_t  id;
  } vinsn_t;

endpackage

// ==== hdl/lane_sequencer.sv ====
`timescale 1ns/1ps
/* Lane sequencer
   Takes one instruction at a time, hands it to the requester and the ALU,
   and signals completion once both are finished */

module lane_sequencer import lane_isa_pkg::*; import lane_bus_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  vinsn_t   insn_i,
  input  logic     insn_valid_i,
  output logic     insn_ready_o,
  output vinsn_t   cmd_o,
  output logic     cmd_valid_o,
  input  logic     cmd_ready_i,
  output alu_cmd_t alu_cmd_o,
  output logic     alu_cmd_valid_o,
  input  logic     alu_cmd_ready_i,
  input  logic     wb_done_i,
  input  logic     alu_idle_i,
  output logic     done_o,
  output vid_t     done_id_o
);

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT
  } state_e;

  state_e state_q, state_d;
  vinsn_t insn_q;
  logic   cmd_sent_q, alu_sent_q, wb_seen_q;
  logic   cmd_fire, alu_fire;

  assign insn_ready_o    = (state_q == IDLE);
  assign cmd_o           = insn_q;
  assign cmd_valid_o     = (state_q == ISSUE) && !cmd_sent_q;
  assign alu_cmd_o       = '{op: insn_q.op, vl: insn_q.vl};
  assign alu_cmd_valid_o = (state_q == ISSUE) && !alu_sent_q;
  assign cmd_fire        = cmd_valid_o && cmd_ready_i;
  assign alu_fire        = alu_cmd_valid_o && alu_cmd_ready_i;

  // Writeback pulse may arrive before the ALU drains, so it is remembered
  assign done_o    = (state_q == WAIT) && (wb_seen_q || wb_done_i) && alu_idle_i;
  assign done_id_o = insn_q.id;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:  if (insn_valid_i) state_d = ISSUE;
      ISSUE: if ((cmd_sent_q || cmd_fire) && (alu_sent_q || alu_fire)) state_d = WAIT;
      WAIT:  if (done_o) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      cmd_sent_q <= 1'b0;
      alu_sent_q <= 1'b0;
      wb_seen_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == IDLE) begin
        cmd_sent_q <= 1'b0;
        alu_sent_q <= 1'b0;
        wb_seen_q  <= 1'b0;
      end else begin
        cmd_sent_q <= cmd_sent_q || cmd_fire;
        alu_sent_q <= alu_sent_q || alu_fire;
        wb_seen_q  <= wb_seen_q || wb_done_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (insn_valid_i && insn_ready_o) insn_q <= insn_i;
  end

  // One writeback report per accepted instruction
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_done_i |-> (state_q != IDLE) && !wb_seen_q);

endmodule

// ==== hdl/operand_requester.sv ====
`timescale 1ns/1ps
/* Operand requester
   Walks the elements of the current instruction and arbitrates each bank
   between ALU writeback, load writes and operand reads */

`include "lane_cfg.svh"

module operand_requester import lane_isa_pkg::*; import lane_bus_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  vinsn_t                        cmd_i,
  input  logic                          cmd_valid_i,
  output logic                          cmd_ready_o,
  output vrf_req_t [`LANE_NR_BANKS-1:0] vrf_req_o,
  output logic     [`LANE_NR_BANKS-1:0] vrf_req_valid_o,
  input  logic                          qa_ready_i,
  input  logic                          qb_ready_i,
  input  elem_t                         alu_res_i,
  input  logic                          alu_res_valid_i,
  output logic                          alu_res_ready_o,
  input  ldu_wr_t                       ldu_wr_i,
  input  logic                          ldu_valid_i,
  output logic                          ldu_ready_o,
  output logic                          wb_done_o
);

  localparam int unsigned NrBanks = `LANE_NR_BANKS;
  localparam int unsigned BankW   = (NrBanks > 1) ? $clog2(NrBanks) : 1;

  typedef logic [BankW-1:0] bank_t;

  // Element i of register r lives in bank (r + i) mod NrBanks
  function automatic bank_t bank_of(vreg_t r, velem_t i);
    return bank_t'((r + i) % NrBanks);
  endfunction

  function automatic vaddr_t addr_of(vreg_t r, velem_t i);
    return vaddr_t'(r * (`LANE_VLMAX / NrBanks) + i / NrBanks);
  endfunction

  vinsn_t                   cmd_q;
  logic                     busy_q, a_done_q, b_done_q;
  vlen_t                    rd_cnt_q, wr_cnt_q;
  velem_t                   rd_idx, wr_idx;
  bank_t                    wr_bank, ldu_bank, a_bank, b_bank;
  logic                     is_alu, alu_wr, ldu_wr, rd_active;
  logic                     gnt_a, gnt_b, elem_done;
  logic [NrBanks-1:0]       wr_busy;
  // Per bank: {read B, read A, load write, ALU write}
  logic [NrBanks-1:0][3:0]  acc;

  assign cmd_ready_o = !busy_q;
  assign is_alu      = busy_q && (cmd_q.op != VOP_STORE);
  assign rd_idx      = velem_t'(rd_cnt_q);
  assign wr_idx      = velem_t'(wr_cnt_q);
  assign wr_bank     = bank_of(cmd_q.vd, wr_idx);
  assign ldu_bank    = bank_of(ldu_wr_i.vreg, ldu_wr_i.idx);
  assign a_bank      = bank_of(cmd_q.vs1, rd_idx);
  assign b_bank      = bank_of(cmd_q.vs2, rd_idx);

  ////////////////////////////////////////
  // Writes first, ALU before load unit
  ////////////////////////////////////////

  assign alu_res_ready_o = is_alu;
  assign alu_wr          = is_alu && alu_res_valid_i;
  assign ldu_ready_o     = !(alu_wr && (ldu_bank == wr_bank));
  assign ldu_wr          = ldu_valid_i && ldu_ready_o;

  always_comb begin
    for (int b = 0; b < NrBanks; b++) begin
      wr_busy[b] = (alu_wr && (wr_bank == bank_t'(b))) || (ldu_wr && (ldu_bank == bank_t'(b)));
    end
  end

  ////////////////////////////////////////
  // Operand reads
  ////////////////////////////////////////

  assign rd_active = busy_q && (rd_cnt_q < cmd_q.vl);

  // Same-bank operands are split, vs1 goes first
  assign gnt_a = rd_active && is_alu && !a_done_q && qa_ready_i && !wr_busy[a_bank];
  assign gnt_b = rd_active && !b_done_q && qb_ready_i && !wr_busy[b_bank] &&
                 !(gnt_a && (a_bank == b_bank));
  assign elem_done = rd_active && (a_done_q || gnt_a || !is_alu) && (b_done_q || gnt_b);

  assign wb_done_o = is_alu ? (alu_wr && (wr_cnt_q == cmd_q.vl - 1))
                            : (busy_q && gnt_b && (rd_cnt_q == cmd_q.vl - 1));

  always_comb begin
    for (int b = 0; b < NrBanks; b++) begin
      acc[b] = {gnt_b && (b_bank == bank_t'(b)), gnt_a && (a_bank == bank_t'(b)),
                ldu_wr && (ldu_bank == bank_t'(b)), alu_wr && (wr_bank == bank_t'(b))};
      vrf_req_valid_o[b] = |acc[b];
      vrf_req_o[b]       = '0;
      if (acc[b][0]) begin
        vrf_req_o[b] = '{we: 1'b1, addr: addr_of(cmd_q.vd, wr_idx), wdata: alu_res_i, tgt: OPQ_A};
      end else if (acc[b][1]) begin
        vrf_req_o[b] = '{we: 1'b1, addr: addr_of(ldu_wr_i.vreg, ldu_wr_i.idx),
                         wdata: ldu_wr_i.data, tgt: OPQ_A};
      end else if (acc[b][2]) begin
        vrf_req_o[b] = '{we: 1'b0, addr: addr_of(cmd_q.vs1, rd_idx), wdata: '0, tgt: OPQ_A};
      end else if (acc[b][3]) begin
        vrf_req_o[b] = '{we: 1'b0, addr: addr_of(cmd_q.vs2, rd_idx), wdata: '0, tgt: OPQ_B};
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q   <= 1'b0;
      rd_cnt_q <= '0;
      wr_cnt_q <= '0;
      a_done_q <= 1'b0;
      b_done_q <= 1'b0;
    end else if (cmd_valid_i && cmd_ready_o) begin
      busy_q   <= 1'b1;
      rd_cnt_q <= '0;
      wr_cnt_q <= '0;
      a_done_q <= 1'b0;
      b_done_q <= 1'b0;
    end else begin
      if (wb_done_o) busy_q <= 1'b0;
      if (alu_wr) wr_cnt_q <= wr_cnt_q + 1'b1;
      if (elem_done) begin
        rd_cnt_q <= rd_cnt_q + 1'b1;
        a_done_q <= 1'b0;
        b_done_q <= 1'b0;
      end else begin
        a_done_q <= a_done_q || gnt_a;
        b_done_q <= b_done_q || gnt_b;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_valid_i && cmd_ready_o) cmd_q <= cmd_i;
  end

  // ALU results only come for an ALU instruction and never beyond vl
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    alu_res_valid_i |-> is_alu && (wr_cnt_q < cmd_q.vl));

endmodule

// ==== hdl/stream_buffer.sv ====
`timescale 1ns/1ps
/* Stream buffer
   Circular valid/ready FIFO for any payload type */

module stream_buffer #(
  parameter type         payload_t = logic,
  parameter int unsigned Depth     = 2
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  payload_t data_i,
  input  logic     valid_i,
  output logic     ready_o,
  output payload_t data_o,
  output logic     valid_o,
  input  logic     ready_i
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  payload_t            mem_q [Depth];
  logic     [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic     [CntW-1:0] count_q;
  logic                full, push, pop;

  assign full    = (count_q == CntW'(Depth));
  // Deep queues keep one slot spare for a read already in flight
  assign ready_o = (Depth > 1) ? (count_q + 2 <= Depth) : !full;
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign push    = valid_i && !full;
  assign pop     = valid_o && ready_i;

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= data_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      count_q <= count_q + CntW'(push) - CntW'(pop);
    end
  end

  // Operand queues take read data unconditionally, so the credit must hold
  if (Depth > 1) begin : gen_full_chk
    assert property (@(posedge clk_i) disable iff (!rst_ni) valid_i |-> !full);
  end

endmodule

// ==== hdl/vector_alu.sv ====
`timescale 1ns/1ps
/* Vector ALU
   Element-wise integer operations behind one output register, which also
   carries STORE operands out to the store port */

module vector_alu import lane_isa_pkg::*; import lane_bus_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  alu_cmd_t cmd_i,
  input  logic     cmd_valid_i,
  output logic     cmd_ready_o,
  input  elem_t    opa_i,
  input  logic     opa_valid_i,
  output logic     opa_ready_o,
  input  elem_t    opb_i,
  input  logic     opb_valid_i,
  output logic     opb_ready_o,
  output elem_t    res_o,
  output logic     res_valid_o,
  input  logic     res_ready_i,
  output elem_t    stu_operand_o,
  output logic     stu_valid_o,
  input  logic     stu_ready_i,
  output logic     idle_o
);

  alu_cmd_t cmd_q;
  logic     busy_q, out_valid_q;
  vlen_t    cnt_q;
  elem_t    out_q, result;
  logic     is_store, out_ready, pop, last;

  assign is_store    = (cmd_q.op == VOP_STORE);
  assign cmd_ready_o = !busy_q;
  assign idle_o      = !busy_q;
  assign out_ready   = is_store ? stu_ready_i : res_ready_i;

  // Advance when operands are present and the output register frees up
  assign pop = busy_q && (cnt_q < cmd_q.vl) && opb_valid_i && (is_store || opa_valid_i) &&
               (!out_valid_q || out_ready);
  assign opa_ready_o = pop && !is_store;
  assign opb_ready_o = pop;
  assign last        = busy_q && (cnt_q == cmd_q.vl) && (!out_valid_q || out_ready);

  always_comb begin
    case (cmd_q.op)
      VOP_ADD: result = opa_i + opb_i;
      VOP_SUB: result = opa_i - opb_i;
      VOP_AND: result = opa_i & opb_i;
      VOP_OR:  result = opa_i | opb_i;
      VOP_XOR: result = opa_i ^ opb_i;
      default: result = opb_i;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      out_valid_q <= 1'b0;
      cnt_q       <= '0;
    end else begin
      if (cmd_valid_i && cmd_ready_o) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end else if (last) begin
        busy_q <= 1'b0;
      end
      if (pop) begin
        cnt_q       <= cnt_q + 1'b1;
        out_valid_q <= 1'b1;
      end else if (out_ready) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_valid_i && cmd_ready_o) cmd_q <= cmd_i;
    if (pop) out_q <= result;
  end

  assign res_o         = out_q;
  assign res_valid_o   = out_valid_q && !is_store;
  assign stu_operand_o = out_q;
  assign stu_valid_o   = out_valid_q && is_store;

endmodule

// ==== hdl/vector_regfile.sv ====
`timescale 1ns/1ps
/* Vector register file
   Two single-ported banks with registered read data steered to the operand queues */

`include "lane_cfg.svh"

module vector_regfile import lane_isa_pkg::*; import lane_bus_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  vrf_req_t [`LANE_NR_BANKS-1:0] req_i,
  input  logic     [`LANE_NR_BANKS-1:0] req_valid_i,
  // Indexed by opqueue_e
  output elem_t    [1:0]                rdata_o,
  output logic     [1:0]                rdata_valid_o
);

  localparam int unsigned NrWords = `LANE_NR_VREGS * `LANE_VLMAX / `LANE_NR_BANKS;

  elem_t       mem_q [`LANE_NR_BANKS][NrWords];
  elem_t [1:0] rdata_q;
  logic  [1:0] rd_hit, rvalid_q;

  always_comb begin
    rd_hit = '0;
    for (int b = 0; b < `LANE_NR_BANKS; b++) begin
      if (req_valid_i[b] && !req_i[b].we) rd_hit[req_i[b].tgt] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    for (int b = 0; b < `LANE_NR_BANKS; b++) begin
      if (req_valid_i[b] && req_i[b].we) begin
        mem_q[b][req_i[b].addr] <= req_i[b].wdata;
      end else if (req_valid_i[b]) begin
        rdata_q[req_i[b].tgt] <= mem_q[b][req_i[b].addr];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) rvalid_q <= '0;
    else rvalid_q <= rd_hit;
  end

  assign rdata_o       = rdata_q;
  assign rdata_valid_o = rvalid_q;

endmodule

// ==== lane_mini.f ====
+incdir+hdl
hdl/lane_isa_pkg.sv
hdl/lane_bus_pkg.sv
hdl/stream_buffer.sv
hdl/vector_regfile.sv
hdl/vector_alu.sv
hdl/operand_requester.sv
hdl/lane_sequencer.sv
hdl/lane.sv
dv/tb_clk_gen.sv
dv/tb_lane.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the lane testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_lane -f lane_mini.f -o Vtb_lane

./obj_dir/Vtb_lane 2>&1 | tee sim.log

if grep -q "^TEST RESULT: PASS$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi
